// File: source/bru_pkg.sv
package bru_pkg;

	// ----------------------------------------
	// widths

	// physical register number, 64 registers
	localparam int LOG_PR_COUNT = 6;

	// reorder buffer index, 32 entries
	localparam int LOG_ROB_ENTRIES = 5;

	// ----------------------------------------
	// branch unit operation codes

	// unconditional jumps
	localparam logic [3:0] BRU_OP_JALR = 4'b0000;
	localparam logic [3:0] BRU_OP_JAL = 4'b0010;

	// conditional branches, all with the top bit set
	localparam logic [3:0] BRU_OP_BEQ = 4'b1000;
	localparam logic [3:0] BRU_OP_BNE = 4'b1001;
	localparam logic [3:0] BRU_OP_BLT = 4'b1100;
	localparam logic [3:0] BRU_OP_BGE = 4'b1101;
	localparam logic [3:0] BRU_OP_BLTU = 4'b1110;
	localparam logic [3:0] BRU_OP_BGEU = 4'b1111;

	// ----------------------------------------
	// 20-bit immediate as carried from decode

	// jal reads all 20 bits as a halfword offset,
	// branches only the low 12
	typedef union packed {
		logic [19:0] jal;
		struct packed {
			logic [7:0] unused;
			logic [11:0] offset;
		} branch;
	} bru_imm_t;

endpackage

// File: source/bru_target_calc.sv
`timescale 1ns/1ps

module bru_target_calc (
	input logic CLK,
	input logic nRST,

	// from the issue queue
	input logic in_valid,
	output logic in_ready,
	input logic [3:0] in_op,
	input logic [31:0] in_pc,
	input logic [31:0] in_pred_pc,
	input bru_pkg::bru_imm_t in_imm,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] in_dest_pr,
	input logic [bru_pkg::LOG_ROB_ENTRIES-1:0] in_rob_index,

	// to the branch pipeline
	output logic issue_valid,
	input logic issue_ready,
	output logic [3:0] issue_op,
	output logic [31:0] issue_pc,
	output logic [31:0] issue_target_pc,
	output logic [31:0] issue_pred_pc,
	output logic [bru_pkg::LOG_PR_COUNT-1:0] issue_dest_pr,
	output logic [bru_pkg::LOG_ROB_ENTRIES-1:0] issue_rob_index
);

	logic [31:0] target_pc;
	logic in_fire;

	// taken target, offsets are in halfwords
	always_comb begin
		case (in_op)
			bru_pkg::BRU_OP_JAL:
				target_pc = in_pc + {{11{in_imm.jal[19]}}, in_imm.jal, 1'b0};
			bru_pkg::BRU_OP_BEQ, bru_pkg::BRU_OP_BNE,
			bru_pkg::BRU_OP_BLT, bru_pkg::BRU_OP_BGE,
			bru_pkg::BRU_OP_BLTU, bru_pkg::BRU_OP_BGEU:
				target_pc = in_pc + {{19{in_imm.branch.offset[11]}}, in_imm.branch.offset, 1'b0};
			// jalr target needs the register value, keep the prediction
			default:
				target_pc = in_pred_pc;
		endcase
	end

	assign in_ready = ~issue_valid | issue_ready;
	assign in_fire = in_valid & in_ready;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			issue_valid <= 1'b0;
		end else if (in_ready) begin
			issue_valid <= in_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (in_fire) begin
			issue_op <= in_op;
			issue_pc <= in_pc;
			issue_target_pc <= target_pc;
			issue_pred_pc <= in_pred_pc;
			issue_dest_pr <= in_dest_pr;
			issue_rob_index <= in_rob_index;
		end
	end

	// stalled output holds its payload
	assert property (@(posedge CLK) disable iff (!nRST)
		(issue_valid && !issue_ready) |=> issue_valid && $stable({issue_op, issue_pc,
			issue_target_pc, issue_pred_pc, issue_dest_pr, issue_rob_index}))
		else $error("bru_target_calc: issue payload changed under back-pressure");

endmodule

// File: source/bru_iq.sv
`timescale 1ns/1ps

module bru_iq #(
	parameter int BRU_IQ_ENTRIES = 4
) (
	input logic CLK,
	input logic nRST,

	// enqueue from rename
	input logic enq_valid,
	output logic enq_ready,
	input logic [3:0] enq_op,
	input logic [31:0] enq_pc,
	input logic [31:0] enq_pred_pc,
	input bru_pkg::bru_imm_t enq_imm,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] enq_a_pr,
	input logic enq_a_ready,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] enq_b_pr,
	input logic enq_b_ready,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] enq_dest_pr,
	input logic [bru_pkg::LOG_ROB_ENTRIES-1:0] enq_rob_index,

	// writeback wakeup
	input logic wb_valid,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] wb_pr,

	// issue to target stage
	output logic iq_issue_valid,
	input logic iq_issue_ready,
	output logic [3:0] iq_issue_op,
	output logic [31:0] iq_issue_pc,
	output logic [31:0] iq_issue_pred_pc,
	output bru_pkg::bru_imm_t iq_issue_imm,
	output logic [bru_pkg::LOG_PR_COUNT-1:0] iq_issue_dest_pr,
	output logic [bru_pkg::LOG_ROB_ENTRIES-1:0] iq_issue_rob_index,

	// register read request to prf
	output logic prf_req_a_valid,
	output logic [bru_pkg::LOG_PR_COUNT-1:0] prf_req_a_pr,
	output logic prf_req_b_valid,
	output logic [bru_pkg::LOG_PR_COUNT-1:0] prf_req_b_pr
);

	localparam int IDX_W = $clog2(BRU_IQ_ENTRIES);
	localparam int CNT_W = $clog2(BRU_IQ_ENTRIES + 1);
	localparam int PR_W = bru_pkg::LOG_PR_COUNT;
	localparam int ROB_W = bru_pkg::LOG_ROB_ENTRIES;

	// entry 0 is the oldest
	logic [BRU_IQ_ENTRIES-1:0] valid_by_entry, next_valid_by_entry;
	logic [BRU_IQ_ENTRIES-1:0][3:0] op_by_entry, next_op_by_entry;
	logic [BRU_IQ_ENTRIES-1:0][31:0] pc_by_entry, next_pc_by_entry;
	logic [BRU_IQ_ENTRIES-1:0][31:0] pred_pc_by_entry, next_pred_pc_by_entry;
	bru_pkg::bru_imm_t [BRU_IQ_ENTRIES-1:0] imm_by_entry, next_imm_by_entry;
	logic [BRU_IQ_ENTRIES-1:0][PR_W-1:0] a_pr_by_entry, next_a_pr_by_entry;
	logic [BRU_IQ_ENTRIES-1:0][PR_W-1:0] b_pr_by_entry, next_b_pr_by_entry;
	logic [BRU_IQ_ENTRIES-1:0] a_ready_by_entry, next_a_ready_by_entry;
	logic [BRU_IQ_ENTRIES-1:0] b_ready_by_entry, next_b_ready_by_entry;
	logic [BRU_IQ_ENTRIES-1:0][PR_W-1:0] dest_pr_by_entry, next_dest_pr_by_entry;
	logic [BRU_IQ_ENTRIES-1:0][ROB_W-1:0] rob_index_by_entry, next_rob_index_by_entry;

	logic [BRU_IQ_ENTRIES-1:0] a_woken_by_entry, b_woken_by_entry;
	logic [BRU_IQ_ENTRIES-1:0] ready_by_entry;
	logic [BRU_IQ_ENTRIES-1:0] shift_by_entry;
	logic [IDX_W-1:0] sel_index;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] enq_slot;
	logic enq_a_woken, enq_b_woken;
	logic issue_fire, enq_fire;

	// ----------------------------------------
	// wakeup and oldest-ready select

	always_comb begin
		for (int i = 0; i < BRU_IQ_ENTRIES; i++) begin
			a_woken_by_entry[i] = a_ready_by_entry[i] | (wb_valid & (a_pr_by_entry[i] == wb_pr));
			b_woken_by_entry[i] = b_ready_by_entry[i] | (wb_valid & (b_pr_by_entry[i] == wb_pr));
		end
	end

	assign enq_a_woken = enq_a_ready | (wb_valid & (enq_a_pr == wb_pr));
	assign enq_b_woken = enq_b_ready | (wb_valid & (enq_b_pr == wb_pr));

	// stored ready bits only, so a wakeup counts from the next cycle
	assign ready_by_entry = valid_by_entry & a_ready_by_entry & b_ready_by_entry;

	always_comb begin
		iq_issue_valid = 1'b0;
		sel_index = '0;
		for (int i = 0; i < BRU_IQ_ENTRIES; i++) begin
			if (!iq_issue_valid && ready_by_entry[i]) begin
				iq_issue_valid = 1'b1;
				sel_index = IDX_W'(i);
			end
		end
	end

	assign issue_fire = iq_issue_valid & iq_issue_ready;

	assign iq_issue_op = op_by_entry[sel_index];
	assign iq_issue_pc = pc_by_entry[sel_index];
	assign iq_issue_pred_pc = pred_pc_by_entry[sel_index];
	assign iq_issue_imm = imm_by_entry[sel_index];
	assign iq_issue_dest_pr = dest_pr_by_entry[sel_index];
	assign iq_issue_rob_index = rob_index_by_entry[sel_index];

	assign prf_req_a_valid = issue_fire;
	assign prf_req_a_pr = a_pr_by_entry[sel_index];
	assign prf_req_b_valid = issue_fire;
	assign prf_req_b_pr = b_pr_by_entry[sel_index];

	// ----------------------------------------
	// compaction and enqueue

	always_comb begin
		count = '0;
		for (int i = 0; i < BRU_IQ_ENTRIES; i++) begin
			count = count + CNT_W'(valid_by_entry[i]);
			shift_by_entry[i] = issue_fire && (IDX_W'(i) >= sel_index);
		end
	end

	// full only when the top slot is taken
	assign enq_ready = ~valid_by_entry[BRU_IQ_ENTRIES-1];
	assign enq_fire = enq_valid & enq_ready;
	assign enq_slot = count - CNT_W'(issue_fire);

	always_comb begin
		next_valid_by_entry = valid_by_entry;
		next_op_by_entry = op_by_entry;
		next_pc_by_entry = pc_by_entry;
		next_pred_pc_by_entry = pred_pc_by_entry;
		next_imm_by_entry = imm_by_entry;
		next_a_pr_by_entry = a_pr_by_entry;
		next_b_pr_by_entry = b_pr_by_entry;
		next_a_ready_by_entry = a_woken_by_entry;
		next_b_ready_by_entry = b_woken_by_entry;
		next_dest_pr_by_entry = dest_pr_by_entry;
		next_rob_index_by_entry = rob_index_by_entry;

		// younger entries move down over the issued one
		for (int i = 0; i < BRU_IQ_ENTRIES - 1; i++) begin
			if (shift_by_entry[i]) begin
				next_valid_by_entry[i] = valid_by_entry[i+1];
				next_op_by_entry[i] = op_by_entry[i+1];
				next_pc_by_entry[i] = pc_by_entry[i+1];
				next_pred_pc_by_entry[i] = pred_pc_by_entry[i+1];
				next_imm_by_entry[i] = imm_by_entry[i+1];
				next_a_pr_by_entry[i] = a_pr_by_entry[i+1];
				next_b_pr_by_entry[i] = b_pr_by_entry[i+1];
				next_a_ready_by_entry[i] = a_woken_by_entry[i+1];
				next_b_ready_by_entry[i] = b_woken_by_entry[i+1];
				next_dest_pr_by_entry[i] = dest_pr_by_entry[i+1];
				next_rob_index_by_entry[i] = rob_index_by_entry[i+1];
			end
		end
		if (shift_by_entry[BRU_IQ_ENTRIES-1]) begin
			next_valid_by_entry[BRU_IQ_ENTRIES-1] = 1'b0;
		end

		// new op lands in the first free slot after the shift
		for (int i = 0; i < BRU_IQ_ENTRIES; i++) begin
			if (enq_fire && (CNT_W'(i) == enq_slot)) begin
				next_valid_by_entry[i] = 1'b1;
				next_op_by_entry[i] = enq_op;
				next_pc_by_entry[i] = enq_pc;
				next_pred_pc_by_entry[i] = enq_pred_pc;
				next_imm_by_entry[i] = enq_imm;
				next_a_pr_by_entry[i] = enq_a_pr;
				next_b_pr_by_entry[i] = enq_b_pr;
				next_a_ready_by_entry[i] = enq_a_woken;
				next_b_ready_by_entry[i] = enq_b_woken;
				next_dest_pr_by_entry[i] = enq_dest_pr;
				next_rob_index_by_entry[i] = enq_rob_index;
			end
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_by_entry <= '0;
		end else begin
			valid_by_entry <= next_valid_by_entry;
		end
	end

	// entry payload
	always_ff @(posedge CLK) begin
		op_by_entry <= next_op_by_entry;
		pc_by_entry <= next_pc_by_entry;
		pred_pc_by_entry <= next_pred_pc_by_entry;
		imm_by_entry <= next_imm_by_entry;
		a_pr_by_entry <= next_a_pr_by_entry;
		b_pr_by_entry <= next_b_pr_by_entry;
		a_ready_by_entry <= next_a_ready_by_entry;
		b_ready_by_entry <= next_b_ready_by_entry;
		dest_pr_by_entry <= next_dest_pr_by_entry;
		rob_index_by_entry <= next_rob_index_by_entry;
	end

	// ----------------------------------------
	// checks

	// refused enqueue leaves the count to the issue side alone
	assert property (@(posedge CLK) disable iff (!nRST)
		(enq_valid && !enq_ready) |=> count == $past(count) - CNT_W'($past(issue_fire)))
		else $error("bru_iq: refused enqueue changed the entry count");

	// occupied entries form one run from entry 0
	assert property (@(posedge CLK) disable iff (!nRST)
		(valid_by_entry & (valid_by_entry + 1'b1)) == '0)
		else $error("bru_iq: valid bits not contiguous, %b", valid_by_entry);

endmodule

// File: source/bru_issue_top.sv
`timescale 1ns/1ps

module bru_issue_top #(
	parameter int BRU_IQ_ENTRIES = 4
) (
	input logic CLK,
	input logic nRST,

	// enqueue
	input logic enq_valid,
	output logic enq_ready,
	input logic [3:0] enq_op,
	input logic [31:0] enq_pc,
	input logic [31:0] enq_pred_pc,
	input bru_pkg::bru_imm_t enq_imm,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] enq_a_pr,
	input logic enq_a_ready,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] enq_b_pr,
	input logic enq_b_ready,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] enq_dest_pr,
	input logic [bru_pkg::LOG_ROB_ENTRIES-1:0] enq_rob_index,

	// writeback
	input logic wb_valid,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] wb_pr,

	// prf read request
	output logic prf_req_a_valid,
	output logic [bru_pkg::LOG_PR_COUNT-1:0] prf_req_a_pr,
	output logic prf_req_b_valid,
	output logic [bru_pkg::LOG_PR_COUNT-1:0] prf_req_b_pr,

	// issue
	output logic issue_valid,
	input logic issue_ready,
	output logic [3:0] issue_op,
	output logic [31:0] issue_pc,
	output logic [31:0] issue_target_pc,
	output logic [31:0] issue_pred_pc,
	output logic [bru_pkg::LOG_PR_COUNT-1:0] issue_dest_pr,
	output logic [bru_pkg::LOG_ROB_ENTRIES-1:0] issue_rob_index
);

	// ----------------------------------------
	// queue to target stage

	logic iq_issue_valid;
	logic iq_issue_ready;
	logic [3:0] iq_issue_op;
	logic [31:0] iq_issue_pc;
	logic [31:0] iq_issue_pred_pc;
	bru_pkg::bru_imm_t iq_issue_imm;
	logic [bru_pkg::LOG_PR_COUNT-1:0] iq_issue_dest_pr;
	logic [bru_pkg::LOG_ROB_ENTRIES-1:0] iq_issue_rob_index;

	bru_iq #(
		.BRU_IQ_ENTRIES(BRU_IQ_ENTRIES)
	) i_iq (.*);

	bru_target_calc i_target (
		.in_valid(iq_issue_valid),
		.in_ready(iq_issue_ready),
		.in_op(iq_issue_op),
		.in_pc(iq_issue_pc),
		.in_pred_pc(iq_issue_pred_pc),
		.in_imm(iq_issue_imm),
		.in_dest_pr(iq_issue_dest_pr),
		.in_rob_index(iq_issue_rob_index),
		.*
	);

endmodule

// File: tests/bru_checker.sv
`timescale 1ns/1ps

module bru_checker #(
	parameter int BRU_IQ_ENTRIES = 4
) (
	input logic CLK,
	input logic nRST,
	input logic enq_valid,
	input logic enq_ready,
	input logic [3:0] enq_op,
	input logic [31:0] enq_pc,
	input logic [31:0] enq_pred_pc,
	input bru_pkg::bru_imm_t enq_imm,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] enq_a_pr,
	input logic enq_a_ready,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] enq_b_pr,
	input logic enq_b_ready,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] enq_dest_pr,
	input logic [bru_pkg::LOG_ROB_ENTRIES-1:0] enq_rob_index,
	input logic wb_valid,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] wb_pr,
	input logic prf_req_a_valid,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] prf_req_a_pr,
	input logic prf_req_b_valid,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] prf_req_b_pr,
	input logic issue_valid,
	input logic issue_ready,
	input logic [3:0] issue_op,
	input logic [31:0] issue_pc,
	input logic [31:0] issue_target_pc,
	input logic [31:0] issue_pred_pc,
	input logic [bru_pkg::LOG_PR_COUNT-1:0] issue_dest_pr,
	input logic [bru_pkg::LOG_ROB_ENTRIES-1:0] issue_rob_index,
	output int error_count,
	output int issued_count
);

	// per-operation record, keyed by enqueue order
	logic [3:0] m_op [int];
	logic [31:0] m_pc [int];
	logic [31:0] m_pred_pc [int];
	logic [19:0] m_imm [int];
	logic [bru_pkg::LOG_PR_COUNT-1:0] m_a_pr [int];
	logic [bru_pkg::LOG_PR_COUNT-1:0] m_b_pr [int];
	logic m_a_ready [int];
	logic m_b_ready [int];
	logic [31:0] m_dest_pr [int];
	logic [31:0] m_rob_index [int];

	// model queue in age order, then the one slot of the target stage
	int age_q [$];
	int flight_q [$];
	int enq_count = 0;
	int errors = 0;
	int issued = 0;
	logic reset_checked = 1'b0;
	logic stall_prev = 1'b0;
	logic [31:0] held [6];
	logic [31:0] payload [6];
	string field_name [6] = '{"issue_op", "issue_pc", "issue_target_pc", "issue_pred_pc",
		"issue_dest_pr", "issue_rob_index"};

	assign error_count = errors;
	assign issued_count = issued;
	assign payload[0] = 32'(issue_op);
	assign payload[1] = issue_pc;
	assign payload[2] = issue_target_pc;
	assign payload[3] = issue_pred_pc;
	assign payload[4] = 32'(issue_dest_pr);
	assign payload[5] = 32'(issue_rob_index);

	// taken target, offsets counted in halfwords
	function automatic logic [31:0] expected_target(input logic [3:0] op,
			input logic [31:0] pc, input logic [31:0] pred_pc, input logic [19:0] imm);
		case (op)
			bru_pkg::BRU_OP_JAL:
				return pc + (32'($signed(imm)) << 1);
			bru_pkg::BRU_OP_BEQ, bru_pkg::BRU_OP_BNE, bru_pkg::BRU_OP_BLT,
			bru_pkg::BRU_OP_BGE, bru_pkg::BRU_OP_BLTU, bru_pkg::BRU_OP_BGEU:
				return pc + (32'($signed(imm[11:0])) << 1);
			default:
				return pred_pc;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("Error at %0t: %s", $time, what);
		errors++;
	endtask

	always @(posedge CLK) begin
		int s;
		int sel;
		logic [31:0] want [6];
		if (!nRST) begin
			age_q.delete();
			flight_q.delete();
			reset_checked = 1'b0;
			stall_prev = 1'b0;
		end else begin
			// ----------------------------------------
			// state right after reset
			if (!reset_checked) begin
				check_value("enq_ready", 32'(enq_ready), 32'h1);
				check_value("issue_valid", 32'(issue_valid), 32'h0);
				check_value("prf_req_a_valid", 32'(prf_req_a_valid), 32'h0);
				check_value("prf_req_b_valid", 32'(prf_req_b_valid), 32'h0);
				reset_checked = 1'b1;
			end
			check_value("enq_ready", 32'(enq_ready), 32'(age_q.size() < BRU_IQ_ENTRIES));

			// stalled output keeps its payload
			if (stall_prev) begin
				if (issue_valid !== 1'b1) begin
					report_failure("issue_valid dropped while issue_ready was low");
				end
				for (int i = 0; i < 6; i++) begin
					check_value(field_name[i], payload[i], held[i]);
				end
			end

			// ----------------------------------------
			// issue out, in the order sent by the queue
			if (issue_valid && issue_ready) begin
				if (flight_q.size() == 0) begin
					report_failure("issue transfer with no operation sent to the target stage");
				end else begin
					s = flight_q.pop_front();
					want[0] = 32'(m_op[s]);
					want[1] = m_pc[s];
					want[2] = expected_target(m_op[s], m_pc[s], m_pred_pc[s], m_imm[s]);
					want[3] = m_pred_pc[s];
					want[4] = m_dest_pr[s];
					want[5] = m_rob_index[s];
					for (int i = 0; i < 6; i++) begin
						check_value(field_name[i], payload[i], want[i]);
					end
					issued++;
				end
			end

			// prf request marks the queue's issue transfer
			if (prf_req_a_valid !== prf_req_b_valid) begin
				report_failure("PRF read requests for the two sources disagree");
			end
			if (prf_req_a_valid === 1'b1) begin
				sel = -1;
				for (int i = 0; i < age_q.size(); i++) begin
					if (sel < 0 && m_a_ready[age_q[i]] && m_b_ready[age_q[i]]) begin
						sel = i;
					end
				end
				if (sel < 0) begin
					report_failure("PRF request while no queued operation has both sources ready");
				end else begin
					s = age_q[sel];
					check_value("prf_req_a_pr", 32'(prf_req_a_pr), 32'(m_a_pr[s]));
					check_value("prf_req_b_pr", 32'(prf_req_b_pr), 32'(m_b_pr[s]));
					age_q.delete(sel);
					flight_q.push_back(s);
				end
			end

			// ----------------------------------------
			// wakeup, then enqueue with bypass
			if (wb_valid === 1'b1) begin
				for (int i = 0; i < age_q.size(); i++) begin
					s = age_q[i];
					if (m_a_pr[s] == wb_pr) m_a_ready[s] = 1'b1;
					if (m_b_pr[s] == wb_pr) m_b_ready[s] = 1'b1;
				end
			end
			if (enq_valid && enq_ready) begin
				s = enq_count;
				m_op[s] = enq_op;
				m_pc[s] = enq_pc;
				m_pred_pc[s] = enq_pred_pc;
				m_imm[s] = enq_imm;
				m_a_pr[s] = enq_a_pr;
				m_b_pr[s] = enq_b_pr;
				m_a_ready[s] = enq_a_ready || (wb_valid && enq_a_pr == wb_pr);
				m_b_ready[s] = enq_b_ready || (wb_valid && enq_b_pr == wb_pr);
				m_dest_pr[s] = 32'(enq_dest_pr);
				m_rob_index[s] = 32'(enq_rob_index);
				age_q.push_back(s);
				enq_count++;
			end

			stall_prev = issue_valid && !issue_ready;
			held = payload;
		end
	end

endmodule

// File: tests/tb_bru_issue.sv
`timescale 1ns/1ps

module tb_bru_issue;

	localparam int BRU_IQ_ENTRIES = 4;
	localparam int OP_COUNT = 60;
	localparam int RESET_CYCLES = 8;
	localparam int CYCLE_LIMIT = OP_COUNT * 20 + RESET_CYCLES;
	localparam int PR_W = bru_pkg::LOG_PR_COUNT;
	localparam int ROB_W = bru_pkg::LOG_ROB_ENTRIES;

	logic CLK;
	logic nRST;
	logic enq_valid;
	logic enq_ready;
	logic [3:0] enq_op;
	logic [31:0] enq_pc;
	logic [31:0] enq_pred_pc;
	bru_pkg::bru_imm_t enq_imm;
	logic [PR_W-1:0] enq_a_pr;
	logic enq_a_ready;
	logic [PR_W-1:0] enq_b_pr;
	logic enq_b_ready;
	logic [PR_W-1:0] enq_dest_pr;
	logic [ROB_W-1:0] enq_rob_index;
	logic wb_valid;
	logic [PR_W-1:0] wb_pr;
	logic prf_req_a_valid;
	logic [PR_W-1:0] prf_req_a_pr;
	logic prf_req_b_valid;
	logic [PR_W-1:0] prf_req_b_pr;
	logic issue_valid;
	logic issue_ready;
	logic [3:0] issue_op;
	logic [31:0] issue_pc;
	logic [31:0] issue_target_pc;
	logic [31:0] issue_pred_pc;
	logic [PR_W-1:0] issue_dest_pr;
	logic [ROB_W-1:0] issue_rob_index;

	int error_count;
	int issued_count;
	int seed;
	int sent;
	int cycles = 0;
	logic [PR_W-1:0] pending [$];
	logic [3:0] op_table [8];

	bru_issue_top #(.BRU_IQ_ENTRIES(BRU_IQ_ENTRIES)) i_dut (.*);

	bru_checker #(.BRU_IQ_ENTRIES(BRU_IQ_ENTRIES)) i_check (.*);

	initial CLK = 1'b0;
	always #5 CLK = ~CLK;

	// ----------------------------------------
	// run limit
	always @(posedge CLK) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run stopped after %0d cycles, %0d of %0d operations issued",
				cycles, issued_count, OP_COUNT);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic new_operation();
		enq_valid = 1'b1;
		enq_op = op_table[3'($random(seed))];
		enq_pc = 32'($random(seed)) & 32'hffff_fffe;
		enq_pred_pc = 32'($random(seed)) & 32'hffff_fffe;
		enq_imm = 20'($random(seed));
		enq_a_pr = PR_W'($random(seed));
		enq_a_ready = ($random(seed) % 2 == 0);
		enq_b_pr = PR_W'($random(seed));
		enq_b_ready = ($random(seed) % 2 == 0);
		enq_dest_pr = PR_W'($random(seed));
		enq_rob_index = ROB_W'(sent);
	endtask

	// sources left waiting by an accepted op
	task automatic note_pending();
		if (!enq_a_ready) pending.push_back(enq_a_pr);
		if (!enq_b_ready) pending.push_back(enq_b_pr);
	endtask

	task automatic drive_writeback();
		int idx;
		wb_valid = 1'b0;
		if (pending.size() != 0 && $random(seed) % 2 == 0) begin
			idx = int'($unsigned($random(seed)) % pending.size());
			wb_valid = 1'b1;
			wb_pr = pending[idx];
			pending.delete(idx);
		end
	endtask

	initial begin
		logic fired;
		seed = 32'hd8a20bcb;
		sent = 0;
		op_table = '{bru_pkg::BRU_OP_JAL, bru_pkg::BRU_OP_JALR, bru_pkg::BRU_OP_BEQ,
			bru_pkg::BRU_OP_BNE, bru_pkg::BRU_OP_BLT, bru_pkg::BRU_OP_BGE,
			bru_pkg::BRU_OP_BLTU, bru_pkg::BRU_OP_BGEU};
		nRST = 1'b0;
		enq_valid = 1'b0;
		enq_op = '0;
		enq_pc = '0;
		enq_pred_pc = '0;
		enq_imm = '0;
		enq_a_pr = '0;
		enq_a_ready = 1'b0;
		enq_b_pr = '0;
		enq_b_ready = 1'b0;
		enq_dest_pr = '0;
		enq_rob_index = '0;
		wb_valid = 1'b0;
		wb_pr = '0;
		issue_ready = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		nRST = 1'b1;

		// enqueue, wake and stall until every op is in and every source written
		while (sent < OP_COUNT || pending.size() != 0) begin
			if (!enq_valid && sent < OP_COUNT && $random(seed) % 5 != 0) begin
				new_operation();
			end
			drive_writeback();
			issue_ready = ($random(seed) % 4 != 0);
			#1;
			fired = enq_valid && enq_ready;
			@(posedge CLK);
			#1;
			if (fired) begin
				note_pending();
				sent++;
				enq_valid = 1'b0;
			end
		end
		wb_valid = 1'b0;
		issue_ready = 1'b1;
		wait (issued_count == OP_COUNT);
		repeat (4) @(posedge CLK);

		$display("Errors: %0d, operations enqueued: %0d, issued: %0d",
			error_count, sent, issued_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: vlog.f
source/bru_pkg.sv
source/bru_target_calc.sv
source/bru_iq.sv
source/bru_issue_top.sv
tests/bru_checker.sv
tests/tb_bru_issue.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_bru_issue
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
FAIL_MSG ?= Finished with errors

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
